// ==== flist.f ====
+incdir+.
mini_mcu_pkg.sv
tiny_core.sv
data_req_fifo.sv
mm_ram.sv
mini_mcu.sv
tb_mini_mcu.sv

// ==== tb_programs.svh ====
// program helpers for the mini subsystem testbench
// instruction encoders, the random source and the loader tasks

`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// program image, written from word 0 upward
logic [31:0] prog [$];

// 16-bit fibonacci lfsr, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd65;

function automatic logic [31:0] encode_ifmt(input mini_mcu_pkg::opcode_e op,
                                            input logic [3:0] rd, input logic [3:0] rs1,
                                            input logic [19:0] imm);
  mini_mcu_pkg::instr_u w;
  w.i_fmt.op  = op;
  w.i_fmt.rd  = rd;
  w.i_fmt.rs1 = rs1;
  w.i_fmt.imm = imm;
  return w;
endfunction

function automatic logic [31:0] encode_bfmt(input mini_mcu_pkg::opcode_e op,
                                            input logic [3:0] rs1, input logic [3:0] rs2,
                                            input logic [19:0] offset);
  mini_mcu_pkg::instr_u w;
  w.b_fmt.op     = op;
  w.b_fmt.rs1    = rs1;
  w.b_fmt.rs2    = rs2;
  w.b_fmt.offset = offset;
  return w;
endfunction

function automatic logic [31:0] sext20(input logic [19:0] v);
  return {{12{v[19]}}, v};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] random_bits(input int unsigned n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int unsigned i = 0; i < n; i++) begin
    fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    v          = {v[30:0], fb};
  end
  return v;
endfunction

task automatic load_word(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
  @(posedge clk_i);
  load_we_i   <= 1'b1;
  load_addr_i <= addr;
  load_data_i <= data;
endtask

// program, then the peripheral base word every program reads first
task automatic load_program();
  foreach (prog[i]) begin
    load_word(ADDR_W'(i), prog[i]);
  end
  load_word(PTR_WORD, mini_mcu_pkg::MMIO_BASE);
  @(posedge clk_i);
  load_we_i <= 1'b0;
endtask

`endif

// ==== tb_mini_mcu.sv ====
// testbench for the mini test subsystem
// loads small programs through the loader port and checks the pseudo peripherals

`timescale 1ns/1ps
`default_nettype none

module tb_mini_mcu;

  localparam int ADDR_W          = 10;
  localparam int NUM_TESTS       = 7;
  localparam int CYCLES_PER_TEST = 400;

  // word holding MMIO_BASE, read into r14 by every program
  localparam logic [ADDR_W-1:0] PTR_WORD   = 10'h100;
  localparam logic [19:0]       PTR_BYTE   = 20'h00400;
  localparam logic [19:0]       DATA_BYTE  = 20'h00300;
  localparam logic [ADDR_W-1:0] EXTRA_WORD = 10'h0e0;
  localparam logic [19:0]       EXTRA_BYTE = 20'h00380;
  localparam logic [19:0] PASS_OFF = 20'(mini_mcu_pkg::ADDR_PASSED - mini_mcu_pkg::MMIO_BASE);
  localparam logic [19:0] FAIL_OFF = 20'(mini_mcu_pkg::ADDR_FAILED - mini_mcu_pkg::MMIO_BASE);
  localparam logic [19:0] EXIT_OFF = 20'(mini_mcu_pkg::ADDR_EXIT - mini_mcu_pkg::MMIO_BASE);

  logic              clk_i = 1'b0;
  logic              arst_n_i;
  logic              fetch_enable_i;
  logic              load_we_i;
  logic [ADDR_W-1:0] load_addr_i;
  logic [31:0]       load_data_i;
  logic              tests_passed_o;
  logic              tests_failed_o;
  logic [31:0]       exit_value_o;
  logic              exit_valid_o;

  // expectations of the running test
  string       test_name = "none";
  logic [31:0] exp_exit = '0;
  logic        exit_expected = 1'b0;
  logic        pass_expected = 1'b0;
  logic        fail_expected = 1'b0;
  int          exit_count;

  `include "tb_programs.svh"

  always #4 clk_i = ~clk_i;

  mini_mcu dut_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o)
  );

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else report_failure($sformatf("ERROR %s: expected 0x%08h actual 0x%08h",
                                    what, expected, actual));
  endtask

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_count <= 0;
    end else if (exit_valid_o) begin
      exit_count <= exit_count + 1;
    end
  end

  // outputs and request lines idle during reset and in the cycle after it
  a_reset_idle: assert property (@(posedge clk_i)
      (!arst_n_i || $past(!arst_n_i)) |->
      (!tests_passed_o && !tests_failed_o && !exit_valid_o && exit_value_o == 32'd0 &&
       !dut_i.instr_req && !dut_i.data_req))
    else report_failure("outputs or request lines not idle during or right after reset");

  a_exit_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      exit_valid_o |=> !exit_valid_o)
    else report_failure($sformatf("exit_valid_o high for two cycles in test %s", test_name));

  a_exit_once: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      exit_valid_o |-> (exit_expected && exit_count == 0))
    else report_failure($sformatf("unexpected or repeated exit pulse in test %s", test_name));

  a_exit_value: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      exit_valid_o |-> (exit_value_o == exp_exit))
    else report_failure($sformatf("ERROR %s: expected 0x%08h actual 0x%08h",
                                  test_name, exp_exit, $sampled(exit_value_o)));

  a_pass_fail_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(tests_passed_o && tests_failed_o))
    else report_failure($sformatf("passed and failed both high in test %s", test_name));

  a_pass_expected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(tests_passed_o) |-> pass_expected)
    else report_failure($sformatf("tests_passed_o rose in test %s", test_name));

  a_fail_expected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(tests_failed_o) |-> fail_expected)
    else report_failure($sformatf("tests_failed_o rose in test %s", test_name));

  a_levels_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !$fell(tests_passed_o) && !$fell(tests_failed_o))
    else report_failure($sformatf("a pass or fail level dropped in test %s", test_name));

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
    report_failure("timeout, the tests did not finish within the cycle budget");
  end

  task automatic apply_reset();
    @(posedge clk_i);
    arst_n_i       <= 1'b0;
    fetch_enable_i <= 1'b0;
    load_we_i      <= 1'b0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
  endtask

  task automatic start_test(input string name, input logic exit_exp,
                            input logic pass_exp, input logic fail_exp);
    apply_reset();
    test_name     = name;
    exit_expected = exit_exp;
    pass_expected = pass_exp;
    fail_expected = fail_exp;
    prog.delete();
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_LW, 4'd14, 4'd0, PTR_BYTE));
  endtask

  task automatic run_program();
    load_program();
    fetch_enable_i <= 1'b1;
  endtask

  // exit pulse, then a quiet window in which the halted core must stay silent
  task automatic wait_for_exit();
    do @(posedge clk_i); while (exit_valid_o !== 1'b1);
    repeat (50) @(posedge clk_i);
  endtask

  initial begin
    logic [31:0] sum;
    logic [31:0] word;
    logic [19:0] imm;
    int          n;
    int          loop_at;
    int          fail_at;
    int          bne_at [$];

    arst_n_i       <= 1'b0;
    fetch_enable_i <= 1'b0;
    load_we_i      <= 1'b0;
    load_addr_i    <= '0;
    load_data_i    <= '0;

    // reset state with fetch held off
    start_test("reset", 1'b0, 1'b0, 1'b0);
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    check_value("reset passed", 32'd0, 32'(tests_passed_o));
    check_value("reset failed", 32'd0, 32'(tests_failed_o));
    check_value("reset exit_valid", 32'd0, 32'(exit_valid_o));
    check_value("reset exit_value", 32'd0, exit_value_o);

    // chain of li and addi
    start_test("arith", 1'b1, 1'b0, 1'b0);
    sum = '0;
    for (int k = 0; k < 5; k++) begin
      imm = random_bits(20);
      sum = sum + sext20(imm);
      if (k == 0) begin
        prog.push_back(encode_ifmt(mini_mcu_pkg::OP_LI, 4'd1, 4'd0, imm));
      end else begin
        prog.push_back(encode_ifmt(mini_mcu_pkg::OP_ADDI, 4'(k + 1), 4'(k), imm));
      end
    end
    prog.push_back(encode_bfmt(mini_mcu_pkg::OP_SW, 4'd14, 4'd5, EXIT_OFF));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_HALT, 4'd0, 4'd0, 20'd0));
    exp_exit = sum;
    run_program();
    wait_for_exit();

    // prefix sums in r1..r6, stored back to back, loaded into r8..r13
    start_test("order", 1'b1, 1'b0, 1'b0);
    sum = '0;
    for (int k = 0; k < 6; k++) begin
      imm = random_bits(20);
      sum = sum + sext20(imm);
      if (k == 0) begin
        prog.push_back(encode_ifmt(mini_mcu_pkg::OP_LI, 4'd1, 4'd0, imm));
      end else begin
        prog.push_back(encode_ifmt(mini_mcu_pkg::OP_ADDI, 4'(k + 1), 4'(k), imm));
      end
    end
    for (int k = 0; k < 6; k++) begin
      prog.push_back(encode_bfmt(mini_mcu_pkg::OP_SW, 4'd0, 4'(k + 1),
                                 DATA_BYTE + 20'(4 * k)));
    end
    for (int k = 0; k < 6; k++) begin
      prog.push_back(encode_ifmt(mini_mcu_pkg::OP_LW, 4'(k + 8), 4'd0,
                                 DATA_BYTE + 20'(4 * k)));
    end
    // any load that differs from its store branches to the fail path
    for (int k = 0; k < 6; k++) begin
      bne_at.push_back(prog.size());
      prog.push_back(32'd0);
    end
    prog.push_back(encode_bfmt(mini_mcu_pkg::OP_SW, 4'd14, 4'd13, EXIT_OFF));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_HALT, 4'd0, 4'd0, 20'd0));
    fail_at = prog.size();
    prog.push_back(encode_bfmt(mini_mcu_pkg::OP_SW, 4'd14, 4'd0, FAIL_OFF));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_HALT, 4'd0, 4'd0, 20'd0));
    for (int k = 0; k < 6; k++) begin
      prog[bne_at[k]] = encode_bfmt(mini_mcu_pkg::OP_BNE, 4'(k + 8), 4'(k + 1),
                                    20'(fail_at - bne_at[k]));
    end
    exp_exit = sum;
    run_program();
    wait_for_exit();

    // r1 counts to n while r2 accumulates the step
    start_test("loop", 1'b1, 1'b0, 1'b0);
    n = int'(random_bits(4));
    if (n == 0) begin
      n = 15;
    end
    imm = random_bits(20);
    sum = '0;
    for (int k = 0; k < n; k++) begin
      sum = sum + sext20(imm);
    end
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_LI, 4'd1, 4'd0, 20'd0));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_LI, 4'd2, 4'd0, 20'd0));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_LI, 4'd3, 4'd0, 20'(n)));
    loop_at = prog.size();
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_ADDI, 4'd2, 4'd2, imm));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_ADDI, 4'd1, 4'd1, 20'd1));
    prog.push_back(encode_bfmt(mini_mcu_pkg::OP_BNE, 4'd1, 4'd3,
                               20'(loop_at - int'(prog.size()))));
    prog.push_back(encode_bfmt(mini_mcu_pkg::OP_SW, 4'd14, 4'd2, EXIT_OFF));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_HALT, 4'd0, 4'd0, 20'd0));
    exp_exit = sum;
    run_program();
    wait_for_exit();

    start_test("pass", 1'b0, 1'b1, 1'b0);
    prog.push_back(encode_bfmt(mini_mcu_pkg::OP_SW, 4'd14, 4'd0, PASS_OFF));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_HALT, 4'd0, 4'd0, 20'd0));
    run_program();
    do @(posedge clk_i); while (tests_passed_o !== 1'b1);
    repeat (50) @(posedge clk_i);
    @(negedge clk_i);
    check_value("pass passed", 32'd1, 32'(tests_passed_o));
    check_value("pass failed", 32'd0, 32'(tests_failed_o));

    start_test("fail", 1'b0, 1'b0, 1'b1);
    prog.push_back(encode_bfmt(mini_mcu_pkg::OP_SW, 4'd14, 4'd0, FAIL_OFF));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_HALT, 4'd0, 4'd0, 20'd0));
    run_program();
    do @(posedge clk_i); while (tests_failed_o !== 1'b1);
    repeat (50) @(posedge clk_i);
    @(negedge clk_i);
    check_value("fail failed", 32'd1, 32'(tests_failed_o));
    check_value("fail passed", 32'd0, 32'(tests_passed_o));

    // data word placed by the loader past the program
    start_test("loader", 1'b1, 1'b0, 1'b0);
    word = random_bits(32);
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_LW, 4'd5, 4'd0, EXTRA_BYTE));
    prog.push_back(encode_bfmt(mini_mcu_pkg::OP_SW, 4'd14, 4'd5, EXIT_OFF));
    prog.push_back(encode_ifmt(mini_mcu_pkg::OP_HALT, 4'd0, 4'd0, 20'd0));
    exp_exit = word;
    load_word(EXTRA_WORD, word);
    run_program();
    wait_for_exit();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mini_mcu.sv ====
// top of the test subsystem
// core fetches straight from memory, data goes through the request buffer

`timescale 1ns/1ps
`default_nettype none

module mini_mcu #(
  parameter int RAM_ADDR_WIDTH = 10,
  parameter int FIFO_DEPTH     = 4
) (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  wire                      fetch_enable_i,
  input  wire                      load_we_i,
  input  wire [RAM_ADDR_WIDTH-1:0] load_addr_i,
  input  wire [31:0]               load_data_i,
  output logic                     tests_passed_o,
  output logic                     tests_failed_o,
  output logic [31:0]              exit_value_o,
  output logic                     exit_valid_o
);

  // instruction port
  logic                    instr_req;
  logic [31:0]             instr_addr;
  logic                    instr_gnt;
  logic                    instr_rvalid;
  mini_mcu_pkg::instr_u    instr_rdata;

  // core side of the buffer
  logic                    dreq_push;
  mini_mcu_pkg::data_req_t dreq;
  logic                    dreq_full;

  // memory side of the buffer
  logic                    data_req;
  mini_mcu_pkg::data_req_t data_head;
  logic                    data_gnt;
  logic                    data_rvalid;
  logic [31:0]             data_rdata;

  tiny_core core_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .instr_req_o   (instr_req),
    .instr_addr_o  (instr_addr),
    .instr_gnt_i   (instr_gnt),
    .instr_rvalid_i(instr_rvalid),
    .instr_rdata_i (instr_rdata),
    .dreq_push_o   (dreq_push),
    .dreq_o        (dreq),
    .dreq_full_i   (dreq_full),
    .data_rvalid_i (data_rvalid),
    .data_rdata_i  (data_rdata)
  );

  data_req_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) dreq_fifo_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .push_i  (dreq_push),
    .data_i  (dreq),
    .gnt_i   (data_gnt),
    .full_o  (dreq_full),
    .req_o   (data_req),
    .data_o  (data_head)
  );

  mm_ram #(
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
  ) ram_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .data_req_i     (data_req),
    .data_req_data_i(data_head),
    .data_gnt_o     (data_gnt),
    .data_rvalid_o  (data_rvalid),
    .data_rdata_o   (data_rdata),
    .load_we_i      (load_we_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

endmodule

`default_nettype wire

// ==== mm_ram.sv ====
// dual-port word RAM with a loader port and pseudo peripherals
// both ports grant at once and answer one cycle after acceptance

`timescale 1ns/1ps
`default_nettype none

module mm_ram #(
  parameter int RAM_ADDR_WIDTH = 10
) (
  input  wire                       clk_i,
  input  wire                       arst_n_i,

  input  wire                       instr_req_i,
  input  wire  [31:0]               instr_addr_i,
  output logic                      instr_gnt_o,
  output logic                      instr_rvalid_o,
  output mini_mcu_pkg::instr_u      instr_rdata_o,

  input  wire                       data_req_i,
  input  mini_mcu_pkg::data_req_t   data_req_data_i,
  output logic                      data_gnt_o,
  output logic                      data_rvalid_o,
  output logic [31:0]               data_rdata_o,

  input  wire                       load_we_i,
  input  wire  [RAM_ADDR_WIDTH-1:0] load_addr_i,
  input  wire  [31:0]               load_data_i,

  output logic                      tests_passed_o,
  output logic                      tests_failed_o,
  output logic                      exit_valid_o,
  output logic [31:0]               exit_value_o
);

  logic [31:0]               mem [2**RAM_ADDR_WIDTH];
  logic [RAM_ADDR_WIDTH-1:0] instr_idx;
  logic [RAM_ADDR_WIDTH-1:0] data_idx;
  logic                      instr_acc;
  logic                      data_acc;
  logic                      data_is_mmio;
  logic                      data_wr_ram;
  logic                      data_wr_mmio;

  // memory never stalls
  assign instr_gnt_o = instr_req_i;
  assign data_gnt_o  = data_req_i;

  assign instr_acc = instr_req_i && instr_gnt_o;
  assign data_acc  = data_req_i && data_gnt_o;

  // byte address to word index
  assign instr_idx = instr_addr_i[RAM_ADDR_WIDTH+1:2];
  assign data_idx  = data_req_data_i.addr[RAM_ADDR_WIDTH+1:2];

  assign data_is_mmio = (data_req_data_i.addr >= mini_mcu_pkg::MMIO_BASE);
  assign data_wr_ram  = data_acc && data_req_data_i.we && !data_is_mmio;
  assign data_wr_mmio = data_acc && data_req_data_i.we && data_is_mmio;

  // single write port, the loader has priority
  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem[load_addr_i] <= load_data_i;
    end else if (data_wr_ram) begin
      mem[data_idx] <= data_req_data_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_acc) begin
      instr_rdata_o <= mem[instr_idx];
    end
  end

  // peripheral reads return zero
  always_ff @(posedge clk_i) begin
    if (data_acc) begin
      data_rdata_o <= data_is_mmio ? 32'd0 : mem[data_idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_rvalid_o <= 1'b0;
      data_rvalid_o  <= 1'b0;
    end else begin
      instr_rvalid_o <= instr_acc;
      data_rvalid_o  <= data_acc;
    end
  end

  // pseudo peripherals
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
      exit_valid_o   <= 1'b0;
      exit_value_o   <= 32'd0;
    end else begin
      exit_valid_o <= 1'b0;
      if (data_wr_mmio) begin
        case (data_req_data_i.addr)
          mini_mcu_pkg::ADDR_PASSED: tests_passed_o <= 1'b1;
          mini_mcu_pkg::ADDR_FAILED: tests_failed_o <= 1'b1;
          mini_mcu_pkg::ADDR_EXIT: begin
            exit_valid_o <= 1'b1;
            exit_value_o <= data_req_data_i.wdata;
          end
          default: begin
            // other peripheral writes are dropped
            exit_valid_o <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== data_req_fifo.sv ====
// ordered request buffer between the core data port and memory
// circular buffer, the head is presented as a req/gnt request

`timescale 1ns/1ps
`default_nettype none

module data_req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     push_i,
  input  mini_mcu_pkg::data_req_t data_i,
  input  wire                     gnt_i,
  output logic                    full_o,
  output logic                    req_o,
  output mini_mcu_pkg::data_req_t data_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  mini_mcu_pkg::data_req_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;
  logic                    do_push;
  logic                    do_pop;

  assign full_o  = (count == CNT_W'(FIFO_DEPTH));
  assign req_o   = (count != '0);
  assign data_o  = mem[rd_ptr];
  assign do_push = push_i && !full_o;
  assign do_pop  = req_o && gnt_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together keep the count
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== tiny_core.sv ====
// minimal in-order core for the test subsystem
// fetches one word at a time, executes it, posts stores and blocks on loads

`timescale 1ns/1ps
`default_nettype none

module tiny_core (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     fetch_enable_i,

  output logic                    instr_req_o,
  output logic [31:0]             instr_addr_o,
  input  wire                     instr_gnt_i,
  input  wire                     instr_rvalid_i,
  input  mini_mcu_pkg::instr_u    instr_rdata_i,

  output logic                    dreq_push_o,
  output mini_mcu_pkg::data_req_t dreq_o,
  input  wire                     dreq_full_i,
  input  wire                     data_rvalid_i,
  input  wire  [31:0]             data_rdata_i
);

  typedef enum logic [2:0] {
    S_FETCH,
    S_WAIT,
    S_EXEC,
    S_LOAD_WAIT,
    S_HALT
  } state_e;

  state_e               state;
  logic [31:0]          pc;
  mini_mcu_pkg::instr_u ir;
  logic [31:0]          rf [16];

  // stores pushed but not yet answered by memory
  logic [7:0]           st_pending;

  mini_mcu_pkg::opcode_e op;
  logic [3:0]           rs1_idx;
  logic [3:0]           rs2_idx;
  logic [31:0]          rs1_val;
  logic [31:0]          rs2_val;
  logic [31:0]          imm_sext;
  logic                 is_mem;
  logic                 push_taken;
  logic                 load_done;

  // decode through the view that matches the opcode
  always_comb begin
    op = ir.i_fmt.op;
    if (op == mini_mcu_pkg::OP_SW || op == mini_mcu_pkg::OP_BNE) begin
      rs1_idx  = ir.b_fmt.rs1;
      rs2_idx  = ir.b_fmt.rs2;
      imm_sext = {{12{ir.b_fmt.offset[19]}}, ir.b_fmt.offset};
    end else begin
      rs1_idx  = ir.i_fmt.rs1;
      rs2_idx  = 4'd0;
      imm_sext = {{12{ir.i_fmt.imm[19]}}, ir.i_fmt.imm};
    end
    // r0 reads as zero
    rs1_val = (rs1_idx == 4'd0) ? 32'd0 : rf[rs1_idx];
    rs2_val = (rs2_idx == 4'd0) ? 32'd0 : rf[rs2_idx];
  end

  assign is_mem = (op == mini_mcu_pkg::OP_LW) || (op == mini_mcu_pkg::OP_SW);

  assign instr_req_o  = (state == S_FETCH) && fetch_enable_i;
  assign instr_addr_o = pc;

  assign dreq_push_o  = (state == S_EXEC) && is_mem;
  assign dreq_o.addr  = rs1_val + imm_sext;
  assign dreq_o.we    = (op == mini_mcu_pkg::OP_SW);
  assign dreq_o.wdata = rs2_val;

  assign push_taken = dreq_push_o && !dreq_full_i;

  // ordering means the load answer comes after every earlier store answer
  assign load_done = (state == S_LOAD_WAIT) && data_rvalid_i && (st_pending == 8'd0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= S_FETCH;
      pc    <= mini_mcu_pkg::BOOT_ADDR;
    end else begin
      case (state)
        S_FETCH: begin
          if (instr_req_o && instr_gnt_i) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (instr_rvalid_i) begin
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          case (op)
            mini_mcu_pkg::OP_LW: begin
              if (push_taken) begin
                state <= S_LOAD_WAIT;
              end
            end
            mini_mcu_pkg::OP_SW: begin
              // hold the request while the buffer is full
              if (push_taken) begin
                pc    <= pc + 32'd4;
                state <= S_FETCH;
              end
            end
            mini_mcu_pkg::OP_BNE: begin
              if (rs1_val != rs2_val) begin
                pc <= pc + {imm_sext[29:0], 2'b00};
              end else begin
                pc <= pc + 32'd4;
              end
              state <= S_FETCH;
            end
            mini_mcu_pkg::OP_HALT: begin
              state <= S_HALT;
            end
            default: begin
              pc    <= pc + 32'd4;
              state <= S_FETCH;
            end
          endcase
        end
        S_LOAD_WAIT: begin
          if (load_done) begin
            pc    <= pc + 32'd4;
            state <= S_FETCH;
          end
        end
        default: begin
          // halted until reset
          state <= S_HALT;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      st_pending <= 8'd0;
    end else begin
      case ({push_taken && dreq_o.we, data_rvalid_i && (st_pending != 8'd0)})
        2'b10:   st_pending <= st_pending + 8'd1;
        2'b01:   st_pending <= st_pending - 8'd1;
        default: st_pending <= st_pending;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == S_WAIT && instr_rvalid_i) begin
      ir <= instr_rdata_i;
    end
  end

  // register file writes, r0 is never written
  always_ff @(posedge clk_i) begin
    if (state == S_EXEC && ir.i_fmt.rd != 4'd0) begin
      if (op == mini_mcu_pkg::OP_LI) begin
        rf[ir.i_fmt.rd] <= imm_sext;
      end else if (op == mini_mcu_pkg::OP_ADDI) begin
        rf[ir.i_fmt.rd] <= rs1_val + imm_sext;
      end
    end else if (load_done && ir.i_fmt.rd != 4'd0) begin
      rf[ir.i_fmt.rd] <= data_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== mini_mcu_pkg.sv ====
// shared types and constants for the mini test subsystem
// holds the instruction formats, the data request word and the memory map

`default_nettype none

package mini_mcu_pkg;

  // opcode lives in the top four bits of every instruction
  typedef enum logic [3:0] {
    OP_LI   = 4'h0,
    OP_ADDI = 4'h1,
    OP_LW   = 4'h2,
    OP_SW   = 4'h3,
    OP_BNE  = 4'h4,
    OP_HALT = 4'h5
  } opcode_e;

  // immediate format, used by li, addi and lw
  typedef struct packed {
    opcode_e     op;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [19:0] imm;
  } i_fmt_t;

  // two-source format, used by sw and bne
  // rs1 is the base or first compare register, rs2 the data or second compare
  typedef struct packed {
    opcode_e     op;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [19:0] offset;
  } b_fmt_t;

  typedef union packed {
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
  } instr_u;

  // one data access, full word only
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
  } data_req_t;

  // memory map
  localparam logic [31:0] MMIO_BASE   = 32'h2000_0000;
  localparam logic [31:0] ADDR_PASSED = MMIO_BASE + 32'd4;
  localparam logic [31:0] ADDR_FAILED = MMIO_BASE + 32'd8;
  localparam logic [31:0] ADDR_EXIT   = MMIO_BASE + 32'd12;

  // reset pc
  localparam logic [31:0] BOOT_ADDR = 32'h0000_0000;

endpackage

`default_nettype wire
